// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_dcache
LOG ?= sim.log
BUILD ?= build
FAIL_MSG := Simulation finished: FAIL

SRCS := $(filter %.sv,$(shell cat list.f))
BIN := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): list.f $(SRCS)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD) -f list.f

run: $(BIN)
	./$(BIN) +verilator+error+limit+100 > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dcache_asserts.sv ====
`timescale 1ns/1ps

module dcache_asserts (
    input logic                clk,
    input logic                rst,
    input logic                req,
    input logic                addr_ok,
    input logic                data_ok,
    input logic                fetch_req,
    input logic                mem_rvalid,
    input dcache_pkg::mem_wb_t mem_wb
);
    import dcache_pkg::*;

    int assert_errors = 0;
    logic [3:0] beats_left;
    logic refill_pending;

    // refill open from fetch_req until the eighth beat
    always_ff @(posedge clk) begin
        if (rst) begin
            beats_left <= '0;
        end else if (fetch_req) begin
            beats_left <= 4'(words_per_line);
        end else if (mem_rvalid && beats_left != 0) begin
            beats_left <= beats_left - 1'b1;
        end
    end

    assign refill_pending = fetch_req || beats_left != 0;

    a_fetch_pulse: assert property (@(posedge clk) disable iff (rst) fetch_req |=> !fetch_req)
        else begin
            assert_errors++;
            $error("fetch_req high for more than one cycle");
        end

    a_no_data_on_fetch: assert property (@(posedge clk) disable iff (rst)
        !(data_ok && fetch_req))
        else begin
            assert_errors++;
            $error("data_ok in the same cycle as fetch_req");
        end

    a_no_wb_in_refill: assert property (@(posedge clk) disable iff (rst)
        !(mem_wb.valid && refill_pending))
        else begin
            assert_errors++;
            $error("write-back while a refill is pending");
        end

    a_addr_ok_req: assert property (@(posedge clk) disable iff (rst) addr_ok |-> req)
        else begin
            assert_errors++;
            $error("addr_ok without req");
        end

endmodule

bind dcache_top dcache_asserts u_asserts (
    .clk(clk),
    .rst(rst),
    .req(req),
    .addr_ok(addr_ok),
    .data_ok(data_ok),
    .fetch_req(fetch_req),
    .mem_rvalid(mem_rvalid),
    .mem_wb(mem_wb)
);

// ==== dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       req,
    input  dcache_pkg::cpu_req_t                       cpu_req,
    input  logic [dcache_pkg::num_ways-1:0]            way_hit,
    input  dcache_pkg::tag_t [dcache_pkg::num_ways-1:0]  way_tag,
    input  dcache_pkg::line_t [dcache_pkg::num_ways-1:0] way_line,
    input  logic                                       victim_way,
    input  logic                                       victim_dirty,
    input  logic                                       fill_last,
    input  dcache_pkg::bank_t                          fill_bank,
    input  logic                                       mem_rvalid,
    input  dcache_pkg::word_t                          mem_rdata,
    output logic                                       addr_ok,
    output logic                                       data_ok,
    output dcache_pkg::word_t                          rdata,
    output dcache_pkg::index_t                         index,
    output dcache_pkg::tag_t                           tag,
    output logic [dcache_pkg::num_ways-1:0]            tag_we,
    output logic [dcache_pkg::num_ways-1:0]            data_we,
    output dcache_pkg::data_write_t                    data_write,
    output logic                                       hit_strobe,
    output logic                                       hit_way,
    output logic                                       fill_strobe,
    output logic                                       is_write,
    output logic                                       start,
    output logic                                       fetch_req,
    output dcache_pkg::addr_t                          fetch_addr,
    output dcache_pkg::mem_wb_t                        mem_wb
);
    import dcache_pkg::*;

    cache_state_e state;
    cache_state_e state_next;
    cpu_req_t req_q;
    logic miss_way;
    logic hit;
    logic rd_way;
    bank_t req_bank;
    logic [num_ways-1:0] miss_way_oh;

    assign hit = |way_hit;
    assign hit_way = way_hit[1];
    assign req_bank = req_q.addr[word_lsb +: bank_w];

    assign addr_ok = req && (state == s_idle || state == s_done || (state == s_lookup && hit));
    assign data_ok = (state == s_lookup && hit) || state == s_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            miss_way <= 1'b0;
        end else begin
            state <= state_next;
            if (state == s_lookup && !hit) begin
                miss_way <= victim_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            req_q <= cpu_req;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            s_idle, s_done: state_next = addr_ok ? s_lookup : s_idle;
            s_lookup: begin
                if (hit) begin
                    state_next = addr_ok ? s_lookup : s_idle;
                end else begin
                    state_next = victim_dirty ? s_writeback : s_fetch_req;
                end
            end
            s_writeback: state_next = s_fetch_req;
            s_fetch_req: state_next = s_fetch_wait;
            s_fetch_wait: state_next = fill_last ? s_update : s_fetch_wait;
            s_update: state_next = s_done;
            default: state_next = s_idle;
        endcase
    end

    // arrays look up the new request while the held one finishes
    assign index = addr_ok ? cpu_req.addr[offset_w +: index_w] : req_q.addr[offset_w +: index_w];
    assign tag = req_q.addr[addr_w-1 -: tag_w];

    always_comb begin
        miss_way_oh = '0;
        miss_way_oh[miss_way] = 1'b1;
    end

    // tag write clears the hit in s_done, so the refilled way is named directly
    assign rd_way = (state == s_done) ? miss_way : hit_way;
    assign rdata = (data_ok && !req_q.wr) ? way_line[rd_way][req_bank] : '0;

    always_comb begin
        data_we = '0;
        data_write.bank = req_bank;
        data_write.byte_en = req_q.sel;
        data_write.word = req_q.wdata;
        if (state == s_fetch_wait && mem_rvalid) begin
            data_we = miss_way_oh;
            data_write.bank = fill_bank;
            data_write.byte_en = '1;
            data_write.word = mem_rdata;
        end else if (state == s_lookup && hit && req_q.wr) begin
            data_we = way_hit;
        end else if (state == s_update && req_q.wr) begin
            // write-allocate merge after the refill
            data_we = miss_way_oh;
        end
    end

    assign tag_we = (state == s_update) ? miss_way_oh : '0;
    assign hit_strobe = state == s_lookup && hit;
    assign fill_strobe = state == s_update;
    assign is_write = req_q.wr;
    assign start = state == s_fetch_req;
    assign fetch_req = state == s_fetch_req;
    assign fetch_addr = {req_q.addr[addr_w-1:offset_w], {offset_w{1'b0}}};

    assign mem_wb.valid = state == s_writeback;
    assign mem_wb.addr = {way_tag[miss_way], req_q.addr[offset_w +: index_w], {offset_w{1'b0}}};
    assign mem_wb.line = way_line[miss_way];

endmodule

// ==== dcache_data_array.sv ====
`timescale 1ns/1ps

module dcache_data_array (
    input  logic                    clk,
    input  dcache_pkg::index_t      index,
    input  logic                    we,
    input  dcache_pkg::data_write_t data_write,
    output dcache_pkg::line_t       line
);
    import dcache_pkg::*;

    word_t banks [words_per_line][num_sets];
    index_t index_q;

    // writes go to the set of the held request, which is last cycle's index
    always_ff @(posedge clk) begin
        index_q <= index;
        for (int b = 0; b < words_per_line; b++) begin
            line[b] <= banks[b][index];
        end
        if (we) begin
            for (int i = 0; i < sel_w; i++) begin
                if (data_write.byte_en[i]) begin
                    banks[data_write.bank][index_q][8*i +: 8] <= data_write.word[8*i +: 8];
                    // forward to a lookup of the same set in this cycle
                    if (index == index_q) begin
                        line[data_write.bank][8*i +: 8] <= data_write.word[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

// ==== dcache_pkg.sv ====
package dcache_pkg;

    localparam int addr_w = 32;
    localparam int word_w = 32;
    localparam int sel_w = 4;

    // line geometry, word index sits in addr[4:2]
    localparam int words_per_line = 8;
    localparam int offset_w = 5;
    localparam int word_lsb = 2;
    localparam int bank_w = 3;

    localparam int num_sets = 128;
    localparam int index_w = 7;
    localparam int tag_w = 20;
    localparam int num_ways = 2;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [word_w-1:0] word_t;
    typedef logic [sel_w-1:0] sel_t;
    typedef logic [index_w-1:0] index_t;
    typedef logic [tag_w-1:0] tag_t;
    typedef logic [bank_w-1:0] bank_t;

    // bank 0 in the lowest word
    typedef word_t [words_per_line-1:0] line_t;

    typedef struct packed {
        logic wr;
        sel_t sel;
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic valid;
        addr_t addr;
        line_t line;
    } mem_wb_t;

    typedef struct packed {
        bank_t bank;
        sel_t byte_en;
        word_t word;
    } data_write_t;

    typedef enum logic [2:0] {
        s_idle,
        s_lookup,
        s_writeback,
        s_fetch_req,
        s_fetch_wait,
        s_update,
        s_done
    } cache_state_e;

endpackage

// ==== dcache_refill_counter.sv ====
`timescale 1ns/1ps

module dcache_refill_counter (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              beat,
    output dcache_pkg::bank_t bank,
    output logic              last
);
    import dcache_pkg::*;

    bank_t count;

    always_ff @(posedge clk) begin
        if (rst || start) begin
            count <= '0;
        end else if (beat) begin
            count <= count + 1'b1;
        end
    end

    assign bank = count;
    // eighth beat of the line
    assign last = beat && (count == bank_t'(words_per_line - 1));

endmodule

// ==== dcache_replace.sv ====
`timescale 1ns/1ps

module dcache_replace (
    input  logic               clk,
    input  logic               rst,
    input  dcache_pkg::index_t index,
    input  logic               hit_strobe,
    input  logic               hit_way,
    input  logic               fill_strobe,
    input  logic               is_write,
    output logic               victim_way,
    output logic               victim_dirty
);
    import dcache_pkg::*;

    logic [num_sets-1:0] lru;
    logic [num_ways-1:0][num_sets-1:0] dirty;
    index_t index_q;

    // last cycle's index is the held request's set
    always_ff @(posedge clk) begin
        index_q <= index;
    end

    assign victim_way = lru[index_q];
    assign victim_dirty = dirty[victim_way][index_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            lru <= '0;
            dirty <= '0;
        end else if (hit_strobe) begin
            lru[index_q] <= ~hit_way;
            if (is_write) begin
                dirty[hit_way][index_q] <= 1'b1;
            end
        end else if (fill_strobe) begin
            // the filled way becomes most recent
            lru[index_q] <= ~lru[index_q];
            dirty[victim_way][index_q] <= is_write;
        end
    end

endmodule

// ==== dcache_tag_array.sv ====
`timescale 1ns/1ps

module dcache_tag_array (
    input  logic               clk,
    input  logic               rst,
    input  dcache_pkg::index_t index,
    input  dcache_pkg::tag_t   tag,
    input  logic               we,
    output logic               hit,
    output dcache_pkg::tag_t   rtag
);
    import dcache_pkg::*;

    tag_t tags [num_sets];
    logic [num_sets-1:0] valid;
    tag_t tag_q;
    logic valid_q;

    always_ff @(posedge clk) begin
        if (we) begin
            tags[index] <= tag;
        end
        tag_q <= tags[index];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            valid_q <= 1'b0;
        end else begin
            if (we) begin
                valid[index] <= 1'b1;
            end
            valid_q <= valid[index];
        end
    end

    // compared against the held tag
    assign hit = valid_q && (tag_q == tag);
    assign rtag = tag_q;

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  dcache_pkg::cpu_req_t cpu_req,
    input  logic                 mem_rvalid,
    input  dcache_pkg::word_t    mem_rdata,
    output logic                 addr_ok,
    output logic                 data_ok,
    output dcache_pkg::word_t    rdata,
    output logic                 fetch_req,
    output dcache_pkg::addr_t    fetch_addr,
    output dcache_pkg::mem_wb_t  mem_wb
);
    import dcache_pkg::*;

    index_t index;
    tag_t tag;
    logic [num_ways-1:0] way_hit;
    tag_t [num_ways-1:0] way_tag;
    line_t [num_ways-1:0] way_line;
    logic [num_ways-1:0] tag_we;
    logic [num_ways-1:0] data_we;
    data_write_t data_write;
    logic hit_strobe;
    logic hit_way;
    logic fill_strobe;
    logic is_write;
    logic start;
    logic victim_way;
    logic victim_dirty;
    logic fill_last;
    bank_t fill_bank;

    dcache_ctrl u_ctrl (
        .clk(clk), .rst(rst), .req(req), .cpu_req(cpu_req),
        .way_hit(way_hit), .way_tag(way_tag), .way_line(way_line),
        .victim_way(victim_way), .victim_dirty(victim_dirty),
        .fill_last(fill_last), .fill_bank(fill_bank),
        .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
        .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
        .index(index), .tag(tag), .tag_we(tag_we), .data_we(data_we),
        .data_write(data_write), .hit_strobe(hit_strobe), .hit_way(hit_way),
        .fill_strobe(fill_strobe), .is_write(is_write), .start(start),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr), .mem_wb(mem_wb)
    );

    dcache_refill_counter u_counter (
        .clk(clk), .rst(rst), .start(start), .beat(mem_rvalid),
        .bank(fill_bank), .last(fill_last)
    );

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        dcache_tag_array u_tag (
            .clk(clk), .rst(rst), .index(index), .tag(tag), .we(tag_we[w]),
            .hit(way_hit[w]), .rtag(way_tag[w])
        );

        dcache_data_array u_data (
            .clk(clk), .index(index), .we(data_we[w]), .data_write(data_write),
            .line(way_line[w])
        );
    end

    dcache_replace u_replace (
        .clk(clk), .rst(rst), .index(index), .hit_strobe(hit_strobe),
        .hit_way(hit_way), .fill_strobe(fill_strobe), .is_write(is_write),
        .victim_way(victim_way), .victim_dirty(victim_dirty)
    );

endmodule

// ==== list.f ====
dcache_pkg.sv
dcache_refill_counter.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_replace.sv
dcache_ctrl.sv
dcache_top.sv
dcache_asserts.sv
tb_dcache.sv

// ==== tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    // up to three idle cycles before each refill beat
    localparam int gap_bits = 2;
    localparam int burst_len = 4;
    localparam int num_requests = 20;
    localparam int reset_cycles = 10;
    // accept, lookup, write-back, fetch, update and done, plus the slowest refill
    localparam int miss_worst = 6 + words_per_line * (1 << gap_bits);
    localparam int timeout_cycles = reset_cycles + 2 * num_requests * miss_worst;

    logic clk;
    logic rst;
    logic req;
    cpu_req_t cpu_req;
    logic mem_rvalid;
    word_t mem_rdata;
    logic addr_ok;
    logic data_ok;
    word_t rdata;
    logic fetch_req;
    addr_t fetch_addr;
    mem_wb_t mem_wb;

    word_t mem [addr_t];
    logic [31:0] lfsr = 32'hd5da;
    int wb_count = 0;
    addr_t last_wb_addr;
    line_t last_wb_line;
    addr_t last_fetch_addr;
    int checks = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle = 0;
    word_t burst_rdata [$];

    dcache_top u_dcache_top (
        .clk(clk),
        .rst(rst),
        .req(req),
        .cpu_req(cpu_req),
        .mem_rvalid(mem_rvalid),
        .mem_rdata(mem_rdata),
        .addr_ok(addr_ok),
        .data_ok(data_ok),
        .rdata(rdata),
        .fetch_req(fetch_req),
        .fetch_addr(fetch_addr),
        .mem_wb(mem_wb)
    );

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t mem_word(input addr_t a);
        addr_t aligned;
        aligned = {a[addr_w-1:2], 2'b00};
        if (mem.exists(aligned)) begin
            return mem[aligned];
        end
        return aligned ^ 32'hd5da;
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input sel_t sel);
        word_t r;
        r = old_w;
        for (int i = 0; i < sel_w; i++) begin
            if (sel[i]) r[8*i +: 8] = new_w[8*i +: 8];
        end
        return r;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %-28s ok", name);
        end else begin
            tests_failed++;
            $display("test %-28s %0d errors", name, errors - errors_before);
        end
    endtask

    // one request, then wait for its answer; lat counts cycles after acceptance
    task automatic cpu_access(input logic wr, input addr_t addr, input sel_t sel,
                              input word_t wdata, output word_t data, output int lat);
        @(negedge clk);
        req = 1'b1;
        cpu_req.wr = wr;
        cpu_req.sel = sel;
        cpu_req.addr = addr;
        cpu_req.wdata = wdata;
        @(posedge clk);
        while (!addr_ok) @(posedge clk);
        @(negedge clk);
        req = 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!data_ok);
        data = rdata;
    endtask

    // reads issued on consecutive cycles, answers collected in order
    task automatic run_burst(input addr_t addrs [burst_len], output int stalls);
        int sent;
        sent = 0;
        stalls = 0;
        burst_rdata.delete();
        @(negedge clk);
        req = 1'b1;
        cpu_req.wr = 1'b0;
        cpu_req.sel = '1;
        cpu_req.addr = addrs[0];
        while (burst_rdata.size() < burst_len) begin
            @(posedge clk);
            if (data_ok) burst_rdata.push_back(rdata);
            if (req && addr_ok) sent++;
            else if (req) stalls++;
            @(negedge clk);
            if (sent < burst_len) cpu_req.addr = addrs[sent];
            else req = 1'b0;
        end
    endtask

    task automatic serve_refill(input addr_t base);
        int gap;
        for (int b = 0; b < words_per_line; b++) begin
            gap = 0;
            repeat (gap_bits) begin
                lfsr = lfsr_next(lfsr);
                gap = (gap << 1) | int'(lfsr[0]);
            end
            repeat (gap) begin
                @(negedge clk);
                mem_rvalid = 1'b0;
            end
            @(negedge clk);
            mem_rvalid = 1'b1;
            mem_rdata = mem_word(base + addr_t'(4 * b));
        end
        @(negedge clk);
        mem_rvalid = 1'b0;
    endtask

    task automatic read_miss_then_hit();
        addr_t a;
        word_t data;
        int lat;
        a = 32'h0000_1044;
        cpu_access(1'b0, a, '1, '0, data, lat);
        check_word("rdata", data, mem_word(a));
        check_addr("fetch_addr", last_fetch_addr, 32'h0000_1040);
        cpu_access(1'b0, a, '1, '0, data, lat);
        check_word("rdata", data, mem_word(a));
        check_count("hit latency", lat, 1);
    endtask

    task automatic write_hit_partial();
        addr_t a;
        word_t data;
        int lat;
        a = 32'h0000_1048;
        cpu_access(1'b0, a, '1, '0, data, lat);
        check_word("rdata", data, mem_word(a));
        cpu_access(1'b1, a, 4'b0101, 32'ha1b2_c3d4, data, lat);
        check_count("write hit latency", lat, 1);
        // a write answers with zero data
        check_word("rdata", data, '0);
        cpu_access(1'b0, a, '1, '0, data, lat);
        check_word("rdata", data, merge_bytes(mem_word(a), 32'ha1b2_c3d4, 4'b0101));
    endtask

    task automatic write_miss_allocate();
        addr_t a;
        word_t data;
        int lat;
        a = 32'h0000_2088;
        cpu_access(1'b1, a, 4'b1100, 32'h5566_7788, data, lat);
        check_addr("fetch_addr", last_fetch_addr, 32'h0000_2080);
        cpu_access(1'b0, a, '1, '0, data, lat);
        check_word("rdata", data, merge_bytes(mem_word(a), 32'h5566_7788, 4'b1100));
    endtask

    // A, B and C share set 3
    task automatic lru_dirty_evict();
        addr_t a_addr;
        addr_t b_addr;
        addr_t c_addr;
        word_t b_exp;
        word_t data;
        int lat;
        int wb_before;
        a_addr = 32'h0001_0064;
        b_addr = 32'h0002_0068;
        c_addr = 32'h0003_0060;
        b_exp = merge_bytes(mem_word(b_addr), 32'h1122_3344, 4'b0011);
        cpu_access(1'b1, a_addr, '1, 32'h0a0a_0a0a, data, lat);
        cpu_access(1'b1, b_addr, 4'b0011, 32'h1122_3344, data, lat);
        wb_before = wb_count;
        cpu_access(1'b0, a_addr, '1, '0, data, lat);
        check_word("rdata", data, 32'h0a0a_0a0a);
        cpu_access(1'b0, c_addr, '1, '0, data, lat);
        check_word("rdata", data, mem_word(c_addr));
        check_count("write-backs", wb_count - wb_before, 1);
        check_addr("mem_wb.addr", last_wb_addr, {b_addr[addr_w-1:offset_w], 5'b0});
        check_word("mem_wb.line", last_wb_line[b_addr[4:2]], b_exp);
        cpu_access(1'b0, b_addr, '1, '0, data, lat);
        check_word("rdata", data, b_exp);
    endtask

    task automatic clean_evict();
        word_t data;
        int lat;
        int wb_before;
        wb_before = wb_count;
        cpu_access(1'b0, 32'h0001_00a0, '1, '0, data, lat);
        cpu_access(1'b0, 32'h0002_00a4, '1, '0, data, lat);
        cpu_access(1'b0, 32'h0003_00a8, '1, '0, data, lat);
        check_word("rdata", data, mem_word(32'h0003_00a8));
        check_count("write-backs", wb_count - wb_before, 0);
    endtask

    task automatic back_to_back_hits();
        addr_t base;
        addr_t addrs [burst_len];
        word_t data;
        int lat;
        int stalls;
        base = 32'h0000_3000;
        addrs = '{base + 32'h1c, base + 32'h4, base + 32'h10, base + 32'h8};
        cpu_access(1'b0, base, '1, '0, data, lat);
        run_burst(addrs, stalls);
        check_count("stall cycles", stalls, 0);
        for (int i = 0; i < burst_len; i++) begin
            check_word("rdata", burst_rdata[i], mem_word(addrs[i]));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // memory answers each fetch with eight beats
    initial begin
        mem_rvalid = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (fetch_req) begin
                last_fetch_addr = fetch_addr;
                serve_refill(fetch_addr);
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && mem_wb.valid) begin
            wb_count++;
            last_wb_addr = mem_wb.addr;
            last_wb_line = mem_wb.line;
            for (int b = 0; b < words_per_line; b++) begin
                mem[mem_wb.addr + addr_t'(4 * b)] = mem_wb.line[b];
            end
        end
    end

    initial begin
        while (cycle < timeout_cycles) begin
            @(posedge clk);
            cycle++;
        end
        $display("timeout: requests still open after %0d cycles", timeout_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int errors_before;
        int assert_errors;
        rst = 1'b1;
        req = 1'b0;
        cpu_req = '0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        errors_before = errors;
        read_miss_then_hit();
        report_test("read miss then hit", errors_before);
        errors_before = errors;
        write_hit_partial();
        report_test("write hit partial", errors_before);
        errors_before = errors;
        write_miss_allocate();
        report_test("write miss allocate", errors_before);
        errors_before = errors;
        lru_dirty_evict();
        report_test("lru dirty eviction", errors_before);
        errors_before = errors;
        clean_evict();
        report_test("clean eviction", errors_before);
        errors_before = errors;
        back_to_back_hits();
        report_test("back-to-back hits", errors_before);
        assert_errors = u_dcache_top.u_asserts.assert_errors;
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, checks, errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
